// ==== core_top.f ====
+incdir+src
src/rv_isa_pkg.sv
src/core_ctrl_pkg.sv
src/core_ctrl_if.sv
src/regfile.sv
src/fetch_unit.sv
src/decode_unit.sv
src/control_unit.sv
src/execute_unit.sv
src/core_top.sv
test/tb_core_top.sv

// ==== Makefile ====
TB := tb_core_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert --timing -j 0 --top-module $(TB) -f core_top.f

run: build
	@out="$$(./obj_dir/V$(TB))"; echo "$$out"; echo "$$out" | grep -qx 'TEST RESULT: PASS'

lint:
	verilator --lint-only -Wall --timing --top-module core_top -f core_top.f

clean:
	rm -rf obj_dir

// ==== test/tb_core_top.sv ====
`include "core_consts.svh"
`timescale 1ns/1ps

module tb_core_top;

    localparam int          IMEM_WORDS   = 128;
    localparam int          HALT_TIMEOUT = 300;
    localparam logic [31:0] SEED         = 32'h5a63_5af0;

    // RV32I major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    localparam logic [31:0] EBREAK_WORD = {12'd1, 5'd0, 3'b000, 5'd0, 7'b1110011};
    localparam logic [2:0]  BR_F3 [6]   = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};

    logic        clk;
    logic        arst_n;
    logic [31:0] imem_rdata;
    logic [4:0]  dbg_raddr;
    logic [31:0] imem_addr;
    logic [31:0] pc;
    logic        halt;
    logic [31:0] dbg_rdata;

    logic [31:0] imem [IMEM_WORDS];
    logic [31:0] imem_index;
    logic [31:0] exp_val [32];
    bit          exp_set [32];
    int unsigned prog_len;
    int          checks;
    int          errors;
    int          check_base;
    int          error_base;
    int          tests_run;
    bit          timed_out;

    core_top u_core_top (
        .clk         (clk),
        .arst_n_i    (arst_n),
        .imem_rdata_i(imem_rdata),
        .dbg_raddr_i (dbg_raddr),
        .imem_addr_o (imem_addr),
        .pc_o        (pc),
        .halt_o      (halt),
        .dbg_rdata_o (dbg_rdata)
    );

    // Instruction memory answers in the same cycle, outside the model it reads EBREAK
    assign imem_index = (imem_addr - `CORE_RESET_PC) >> 2;
    assign imem_rdata = (imem_index < IMEM_WORDS) ? imem[imem_index[6:0]] : EBREAK_WORD;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input int rs2, input int rs1,
                                          input logic [2:0] f3, input int rd);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [6:0] opc, input int rd,
                                          input logic [2:0] f3, input int rs1,
                                          input logic [11:0] imm);
        return {imm, rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic logic [31:0] enc_u(input logic [6:0] opc, input int rd,
                                          input logic [19:0] imm);
        return {imm, rd[4:0], opc};
    endfunction

    function automatic logic [31:0] enc_b(input logic [2:0] f3, input int rs1, input int rs2,
                                          input logic [12:0] off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input int rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OPC_JAL};
    endfunction

    function automatic logic [31:0] inst_addr(input int idx);
        return `CORE_RESET_PC + 32'(4 * idx);
    endfunction

    // Branch outcome as the ISA defines it
    function automatic bit branch_taken(input logic [2:0] f3, input logic [31:0] x,
                                        input logic [31:0] y);
        case (f3)
            3'b000:  return x == y;
            3'b001:  return x != y;
            3'b100:  return $signed(x) < $signed(y);
            3'b101:  return $signed(x) >= $signed(y);
            3'b110:  return x < y;
            default: return x >= y;
        endcase
    endfunction

    task automatic emit(input logic [31:0] word);
        imem[prog_len] = word;
        prog_len++;
    endtask

    // Always two words, LUI then ADDI
    task automatic emit_li(input int rd, input logic [31:0] value);
        logic [31:0] hi;
        hi = value + 32'h800;
        emit(enc_u(OPC_LUI, rd, hi[31:12]));
        emit(enc_i(OPC_OP_IMM, rd, 3'b000, rd, value[11:0]));
    endtask

    task automatic expect_reg(input int rd, input logic [31:0] value);
        exp_val[rd] = value;
        exp_set[rd] = 1'b1;
    endtask

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] want);
        checks++;
        assert (got === want) else begin
            $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, want);
            errors++;
        end
    endtask

    task automatic begin_program();
        int i;
        @(posedge clk);
        arst_n    <= 1'b0;
        dbg_raddr <= '0;
        @(negedge clk);
        check_base = checks;
        error_base = errors;
        prog_len   = 0;
        // Unused words are ADDI x0 with the word index as immediate
        for (i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = enc_i(OPC_OP_IMM, 0, 3'b000, 0, 12'(i));
        end
        for (i = 0; i < 32; i++) begin
            exp_set[i] = 1'b0;
        end
        expect_reg(0, 32'h0);
    endtask

    // Last emitted word is the EBREAK the core must stop on
    task automatic run_to_halt(input string name);
        int cyc;
        int r;
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        for (cyc = 0; cyc < HALT_TIMEOUT; cyc++) begin
            @(negedge clk);
            if (halt) begin
                break;
            end
        end
        if (!halt) begin
            $display("Timeout: halt_o did not rise within %0d cycles in test %s",
                     HALT_TIMEOUT, name);
            errors++;
            timed_out = 1'b1;
        end else begin
            compare_value("pc_o at halt", pc, inst_addr(prog_len - 1));
            for (r = 0; r < 32; r++) begin
                if (exp_set[r]) begin
                    @(posedge clk);
                    dbg_raddr <= 5'(r);
                    @(negedge clk);
                    compare_value($sformatf("%s x%0d", name, r), dbg_rdata, exp_val[r]);
                end
            end
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        $display("test %s finished: %0d checks, %0d errors", name,
                 checks - check_base, errors - error_base);
    endtask

    task automatic test_alu();
        logic [31:0] a;
        logic [31:0] b;
        logic [11:0] imm;
        logic [31:0] simm;
        logic [4:0]  sh;
        // Negative a and positive b make signed and unsigned compares disagree
        a    = $urandom | 32'h8000_0000;
        b    = $urandom & 32'h7fff_ffff;
        imm  = 12'($urandom);
        simm = {{20{imm[11]}}, imm};
        sh   = 5'($urandom);
        begin_program();
        emit_li(1, a);
        emit_li(2, b);
        emit(enc_r(7'h00, 2, 1, 3'b000, 3));
        emit(enc_r(7'h20, 2, 1, 3'b000, 4));
        emit(enc_r(7'h00, 2, 1, 3'b001, 5));
        emit(enc_r(7'h00, 2, 1, 3'b010, 6));
        emit(enc_r(7'h00, 2, 1, 3'b011, 7));
        emit(enc_r(7'h00, 2, 1, 3'b100, 8));
        emit(enc_r(7'h00, 2, 1, 3'b101, 9));
        emit(enc_r(7'h20, 2, 1, 3'b101, 10));
        emit(enc_r(7'h00, 2, 1, 3'b110, 11));
        emit(enc_r(7'h00, 2, 1, 3'b111, 12));
        emit(enc_r(7'h00, 1, 2, 3'b010, 22));
        emit(enc_i(OPC_OP_IMM, 13, 3'b000, 1, imm));
        emit(enc_i(OPC_OP_IMM, 14, 3'b010, 1, imm));
        emit(enc_i(OPC_OP_IMM, 15, 3'b011, 1, imm));
        emit(enc_i(OPC_OP_IMM, 16, 3'b100, 1, imm));
        emit(enc_i(OPC_OP_IMM, 17, 3'b110, 1, imm));
        emit(enc_i(OPC_OP_IMM, 18, 3'b111, 1, imm));
        emit(enc_i(OPC_OP_IMM, 19, 3'b001, 1, {7'h00, sh}));
        emit(enc_i(OPC_OP_IMM, 20, 3'b101, 1, {7'h00, sh}));
        emit(enc_i(OPC_OP_IMM, 21, 3'b101, 1, {7'h20, sh}));
        emit(EBREAK_WORD);
        expect_reg(3, a + b);
        expect_reg(4, a - b);
        expect_reg(5, a << b[4:0]);
        expect_reg(6, 32'($signed(a) < $signed(b)));
        expect_reg(7, 32'(a < b));
        expect_reg(8, a ^ b);
        expect_reg(9, a >> b[4:0]);
        expect_reg(10, $signed(a) >>> b[4:0]);
        expect_reg(11, a | b);
        expect_reg(12, a & b);
        expect_reg(22, 32'($signed(b) < $signed(a)));
        expect_reg(13, a + simm);
        expect_reg(14, 32'($signed(a) < $signed(simm)));
        expect_reg(15, 32'(a < simm));
        expect_reg(16, a ^ simm);
        expect_reg(17, a | simm);
        expect_reg(18, a & simm);
        expect_reg(19, a << sh);
        expect_reg(20, a >> sh);
        expect_reg(21, $signed(a) >>> sh);
        run_to_halt("alu");
        end_test("alu");
    endtask

    task automatic test_x0();
        begin_program();
        emit_li(1, $urandom | 32'h1);
        emit_li(23, $urandom | 32'h1);
        emit(enc_i(OPC_OP_IMM, 0, 3'b000, 1, 12'h123));
        emit(enc_r(7'h00, 1, 1, 3'b000, 0));
        emit(enc_u(OPC_LUI, 0, 20'habcde));
        // x0 as a source after the discarded writes
        emit(enc_r(7'h00, 0, 0, 3'b000, 23));
        emit(enc_i(OPC_OP_IMM, 24, 3'b000, 0, 12'h005));
        emit(EBREAK_WORD);
        expect_reg(23, 32'h0);
        expect_reg(24, 32'h5);
        run_to_halt("x0");
        end_test("x0");
    endtask

    task automatic test_branches();
        logic [31:0] p;
        logic [31:0] n;
        int          k;
        int          pair;
        int          rs1;
        int          rs2;
        int          mk;
        p  = $urandom & 32'h7fff_ffff;
        n  = $urandom | 32'h8000_0000;
        mk = 3;
        begin_program();
        emit_li(1, p);
        emit_li(2, n);
        for (k = 0; k < 6; k++) begin
            for (pair = 0; pair < 3; pair++) begin
                rs1 = (pair == 1) ? 2 : 1;
                rs2 = (pair == 0) ? 2 : 1;
                // Marker is set only when the branch falls through
                emit(enc_i(OPC_OP_IMM, mk, 3'b000, 0, 12'd0));
                emit(enc_b(BR_F3[k], rs1, rs2, 13'd8));
                emit(enc_i(OPC_OP_IMM, mk, 3'b000, 0, 12'd1));
                expect_reg(mk, branch_taken(BR_F3[k], (rs1 == 1) ? p : n,
                                            (rs2 == 1) ? p : n) ? 32'd0 : 32'd1);
                mk++;
            end
        end
        emit(EBREAK_WORD);
        run_to_halt("branch");
        end_test("branch");
    endtask

    task automatic test_jumps();
        logic [31:0] jalr_base;
        // Odd base, the target must come out with bit 0 cleared
        jalr_base = inst_addr(12) - 32'd8 + 32'd1;
        begin_program();
        emit(enc_i(OPC_OP_IMM, 6, 3'b000, 0, 12'd0));
        emit(enc_i(OPC_OP_IMM, 10, 3'b000, 0, 12'd0));
        emit(enc_j(5, 21'd12));
        emit(enc_i(OPC_OP_IMM, 6, 3'b000, 0, 12'd1));
        emit(EBREAK_WORD);
        emit(enc_i(OPC_OP_IMM, 7, 3'b000, 0, 12'd7));
        emit_li(8, jalr_base);
        emit(enc_i(OPC_JALR, 9, 3'b000, 8, 12'd8));
        emit(enc_i(OPC_OP_IMM, 10, 3'b000, 0, 12'd1));
        emit(EBREAK_WORD);
        emit(EBREAK_WORD);
        emit(enc_i(OPC_OP_IMM, 11, 3'b000, 0, 12'd11));
        emit(EBREAK_WORD);
        expect_reg(5, inst_addr(3));
        expect_reg(6, 32'd0);
        expect_reg(7, 32'd7);
        expect_reg(9, inst_addr(9));
        expect_reg(10, 32'd0);
        expect_reg(11, 32'd11);
        run_to_halt("jump");
        end_test("jump");
    endtask

    task automatic test_upper();
        logic [19:0] u1;
        logic [19:0] u2;
        u1 = 20'($urandom);
        u2 = 20'($urandom);
        begin_program();
        emit(enc_u(OPC_LUI, 12, u1));
        emit(enc_u(OPC_AUIPC, 13, u2));
        emit(enc_u(OPC_AUIPC, 14, 20'h0));
        emit(EBREAK_WORD);
        expect_reg(12, {u1, 12'h0});
        expect_reg(13, inst_addr(1) + {u2, 12'h0});
        expect_reg(14, inst_addr(2));
        run_to_halt("upper");
        end_test("upper");
    endtask

    task automatic test_halt();
        int k;
        begin_program();
        emit(enc_i(OPC_OP_IMM, 1, 3'b000, 0, 12'h0a5));
        emit(EBREAK_WORD);
        expect_reg(1, 32'h0a5);
        run_to_halt("halt");
        if (!timed_out) begin
            for (k = 0; k < 6; k++) begin
                @(negedge clk);
                compare_value("halt_o after EBREAK", 32'(halt), 32'd1);
                compare_value("pc_o after EBREAK", pc, inst_addr(1));
            end
            @(posedge clk);
            arst_n <= 1'b0;
            @(negedge clk);
            compare_value("pc_o in reset", pc, `CORE_RESET_PC);
            compare_value("halt_o in reset", 32'(halt), 32'd0);
            repeat (8) @(posedge clk);
            arst_n <= 1'b1;
            @(negedge clk);
            compare_value("pc_o after reset", pc, `CORE_RESET_PC);
            compare_value("halt_o after reset", 32'(halt), 32'd0);
        end
        end_test("halt");
    endtask

    initial begin
        arst_n    = 1'b0;
        dbg_raddr = '0;
        checks    = 0;
        errors    = 0;
        tests_run = 0;
        timed_out = 1'b0;
        prog_len  = 0;
        void'($urandom(SEED));
        test_alu();
        if (!timed_out) test_x0();
        if (!timed_out) test_branches();
        if (!timed_out) test_jumps();
        if (!timed_out) test_upper();
        if (!timed_out) test_halt();
        $display("Tests run %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== src/core_top.sv ====
`include "core_consts.svh"
`timescale 1ns/1ps

module core_top (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  logic [`CORE_XLEN-1:0]   imem_rdata_i,
    input  logic [`CORE_REG_AW-1:0] dbg_raddr_i,
    output logic [`CORE_XLEN-1:0]   imem_addr_o,
    output logic [`CORE_XLEN-1:0]   pc_o,
    output logic                    halt_o,
    output logic [`CORE_XLEN-1:0]   dbg_rdata_o
);

    logic [`CORE_XLEN-1:0]   pc;
    logic [`CORE_XLEN-1:0]   pc_plus4;
    logic [`CORE_XLEN-1:0]   inst;
    logic [`CORE_REG_AW-1:0] rs1_addr;
    logic [`CORE_REG_AW-1:0] rs2_addr;
    logic [`CORE_REG_AW-1:0] rd_addr;
    logic [`CORE_XLEN-1:0]   rs1_data;
    logic [`CORE_XLEN-1:0]   rs2_data;
    logic [`CORE_XLEN-1:0]   op1;
    logic [`CORE_XLEN-1:0]   op2;
    logic [`CORE_XLEN-1:0]   br_target;
    logic [`CORE_XLEN-1:0]   jal_target;
    logic [`CORE_XLEN-1:0]   jalr_target;
    logic                    br_eq;
    logic                    br_lt;
    logic                    br_ltu;
    logic [`CORE_XLEN-1:0]   wb_data;

    core_ctrl_if u_ctrl_if ();

    regfile #(
        .ADDR_WIDTH(`CORE_REG_AW),
        .DATA_WIDTH(`CORE_XLEN)
    ) u_regfile (
        .clk        (clk),
        .we_i       (u_ctrl_if.rf_we),
        .waddr_i    (rd_addr),
        .wdata_i    (wb_data),
        .raddr1_i   (rs1_addr),
        .raddr2_i   (rs2_addr),
        .dbg_raddr_i(dbg_raddr_i),
        .rdata1_o   (rs1_data),
        .rdata2_o   (rs2_data),
        .dbg_rdata_o(dbg_rdata_o)
    );

    fetch_unit u_fetch_unit (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .ctrl         (u_ctrl_if.fetch),
        .br_target_i  (br_target),
        .jal_target_i (jal_target),
        .jalr_target_i(jalr_target),
        .inst_i       (imem_rdata_i),
        .pc_o         (pc),
        .pc_plus4_o   (pc_plus4),
        .inst_o       (inst)
    );

    decode_unit u_decode_unit (
        .inst_i       (inst),
        .pc_i         (pc),
        .ctrl         (u_ctrl_if.decode),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .rs1_addr_o   (rs1_addr),
        .rs2_addr_o   (rs2_addr),
        .rd_addr_o    (rd_addr),
        .op1_o        (op1),
        .op2_o        (op2),
        .br_target_o  (br_target),
        .jal_target_o (jal_target),
        .jalr_target_o(jalr_target),
        .br_eq_o      (br_eq),
        .br_lt_o      (br_lt),
        .br_ltu_o     (br_ltu)
    );

    control_unit u_control_unit (
        .inst_i  (inst),
        .br_eq_i (br_eq),
        .br_lt_i (br_lt),
        .br_ltu_i(br_ltu),
        .ctrl    (u_ctrl_if.ctrl),
        .halt_o  (halt_o)
    );

    execute_unit u_execute_unit (
        .op1_i     (op1),
        .op2_i     (op2),
        .pc_plus4_i(pc_plus4),
        .ctrl      (u_ctrl_if.exec),
        .wb_data_o (wb_data)
    );

    assign imem_addr_o = pc;
    // Debug view of the PC
    assign pc_o        = pc;

    // Once halted the core stays halted on the same PC until reset
    a_halt_sticky: assert property (
        @(posedge clk) disable iff (!arst_n_i) halt_o |=> halt_o && $stable(pc)
    );

endmodule

// ==== src/execute_unit.sv ====
`include "core_consts.svh"
`timescale 1ns/1ps

module execute_unit (
    input  logic [`CORE_XLEN-1:0] op1_i,
    input  logic [`CORE_XLEN-1:0] op2_i,
    input  logic [`CORE_XLEN-1:0] pc_plus4_i,
    core_ctrl_if.exec             ctrl,
    output logic [`CORE_XLEN-1:0] wb_data_o
);

    logic [`CORE_XLEN-1:0] alu_res;
    logic [4:0]            shamt;

    // RV32I shifts only look at the low five bits
    assign shamt = op2_i[4:0];

    always_comb begin
        case (ctrl.alu_op)
            rv_isa_pkg::ADD:   alu_res = op1_i + op2_i;
            rv_isa_pkg::SUB:   alu_res = op1_i - op2_i;
            rv_isa_pkg::SLL:   alu_res = op1_i << shamt;
            rv_isa_pkg::SLT:   alu_res = `CORE_XLEN'($signed(op1_i) < $signed(op2_i));
            rv_isa_pkg::SLTU:  alu_res = `CORE_XLEN'(op1_i < op2_i);
            rv_isa_pkg::XOR:   alu_res = op1_i ^ op2_i;
            rv_isa_pkg::SRL:   alu_res = op1_i >> shamt;
            rv_isa_pkg::SRA:   alu_res = $unsigned($signed(op1_i) >>> shamt);
            rv_isa_pkg::OR:    alu_res = op1_i | op2_i;
            rv_isa_pkg::AND:   alu_res = op1_i & op2_i;
            rv_isa_pkg::COPY2: alu_res = op2_i;
            default:           alu_res = '0;
        endcase
    end

    assign wb_data_o = (ctrl.wb_sel == core_ctrl_pkg::WB_PC4) ? pc_plus4_i : alu_res;

endmodule

// ==== src/control_unit.sv ====
`include "core_consts.svh"
`timescale 1ns/1ps

module control_unit (
    input  logic [`CORE_XLEN-1:0] inst_i,
    input  logic                  br_eq_i,
    input  logic                  br_lt_i,
    input  logic                  br_ltu_i,
    core_ctrl_if.ctrl             ctrl,
    output logic                  halt_o
);

    rv_isa_pkg::opcode_e opcode;
    logic [2:0]          funct3;
    logic                funct7_b5;
    logic                br_taken;
    rv_isa_pkg::alu_op_e alu_f3_op;

    assign opcode    = rv_isa_pkg::opcode_e'(inst_i[6:0]);
    assign funct3    = inst_i[14:12];
    assign funct7_b5 = inst_i[30];

    // Branch condition from the decode compare flags
    always_comb begin
        case (rv_isa_pkg::br_funct3_e'(funct3))
            rv_isa_pkg::BEQ:  br_taken = br_eq_i;
            rv_isa_pkg::BNE:  br_taken = !br_eq_i;
            rv_isa_pkg::BLT:  br_taken = br_lt_i;
            rv_isa_pkg::BGE:  br_taken = !br_lt_i;
            rv_isa_pkg::BLTU: br_taken = br_ltu_i;
            rv_isa_pkg::BGEU: br_taken = !br_ltu_i;
            default:          br_taken = 1'b0;
        endcase
    end

    // ALU op shared by OP and OP_IMM; SUB only exists in the register form
    always_comb begin
        case (rv_isa_pkg::alu_funct3_e'(funct3))
            rv_isa_pkg::F3_ADD: begin
                alu_f3_op = (funct7_b5 && opcode == rv_isa_pkg::OP) ? rv_isa_pkg::SUB
                                                                     : rv_isa_pkg::ADD;
            end
            rv_isa_pkg::F3_SLL:  alu_f3_op = rv_isa_pkg::SLL;
            rv_isa_pkg::F3_SLT:  alu_f3_op = rv_isa_pkg::SLT;
            rv_isa_pkg::F3_SLTU: alu_f3_op = rv_isa_pkg::SLTU;
            rv_isa_pkg::F3_XOR:  alu_f3_op = rv_isa_pkg::XOR;
            rv_isa_pkg::F3_SR:   alu_f3_op = funct7_b5 ? rv_isa_pkg::SRA : rv_isa_pkg::SRL;
            rv_isa_pkg::F3_OR:   alu_f3_op = rv_isa_pkg::OR;
            default:             alu_f3_op = rv_isa_pkg::AND;
        endcase
    end

    always_comb begin
        // No-op defaults that unknown opcodes keep
        ctrl.pc_sel  = core_ctrl_pkg::PC_PLUS4;
        ctrl.op1_sel = core_ctrl_pkg::OP1_RS1;
        ctrl.op2_sel = core_ctrl_pkg::OP2_RS2;
        ctrl.alu_op  = rv_isa_pkg::ADD;
        ctrl.wb_sel  = core_ctrl_pkg::WB_ALU;
        ctrl.rf_we   = 1'b0;
        halt_o       = 1'b0;
        case (opcode)
            rv_isa_pkg::OP: begin
                ctrl.alu_op = alu_f3_op;
                ctrl.rf_we  = 1'b1;
            end
            rv_isa_pkg::OP_IMM: begin
                ctrl.op2_sel = core_ctrl_pkg::OP2_IMM_I;
                ctrl.alu_op  = alu_f3_op;
                ctrl.rf_we   = 1'b1;
            end
            rv_isa_pkg::LUI: begin
                ctrl.op1_sel = core_ctrl_pkg::OP1_ZERO;
                ctrl.op2_sel = core_ctrl_pkg::OP2_IMM_U;
                ctrl.alu_op  = rv_isa_pkg::COPY2;
                ctrl.rf_we   = 1'b1;
            end
            rv_isa_pkg::AUIPC: begin
                ctrl.op1_sel = core_ctrl_pkg::OP1_PC;
                ctrl.op2_sel = core_ctrl_pkg::OP2_IMM_U;
                ctrl.rf_we   = 1'b1;
            end
            rv_isa_pkg::JAL: begin
                ctrl.pc_sel = core_ctrl_pkg::PC_JAL;
                ctrl.wb_sel = core_ctrl_pkg::WB_PC4;
                ctrl.rf_we  = 1'b1;
            end
            rv_isa_pkg::JALR: begin
                ctrl.pc_sel = core_ctrl_pkg::PC_JALR;
                ctrl.wb_sel = core_ctrl_pkg::WB_PC4;
                ctrl.rf_we  = 1'b1;
            end
            rv_isa_pkg::BRANCH: begin
                ctrl.pc_sel = br_taken ? core_ctrl_pkg::PC_BRANCH : core_ctrl_pkg::PC_PLUS4;
            end
            rv_isa_pkg::SYSTEM: begin
                if (inst_i == `CORE_EBREAK) begin
                    // Freeze on the EBREAK until reset
                    ctrl.pc_sel = core_ctrl_pkg::PC_HOLD;
                    halt_o      = 1'b1;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== src/decode_unit.sv ====
`include "core_consts.svh"
`timescale 1ns/1ps

module decode_unit (
    input  logic [`CORE_XLEN-1:0]   inst_i,
    input  logic [`CORE_XLEN-1:0]   pc_i,
    core_ctrl_if.decode             ctrl,
    input  logic [`CORE_XLEN-1:0]   rs1_data_i,
    input  logic [`CORE_XLEN-1:0]   rs2_data_i,
    output logic [`CORE_REG_AW-1:0] rs1_addr_o,
    output logic [`CORE_REG_AW-1:0] rs2_addr_o,
    output logic [`CORE_REG_AW-1:0] rd_addr_o,
    output logic [`CORE_XLEN-1:0]   op1_o,
    output logic [`CORE_XLEN-1:0]   op2_o,
    output logic [`CORE_XLEN-1:0]   br_target_o,
    output logic [`CORE_XLEN-1:0]   jal_target_o,
    output logic [`CORE_XLEN-1:0]   jalr_target_o,
    output logic                    br_eq_o,
    output logic                    br_lt_o,
    output logic                    br_ltu_o
);

    logic [`CORE_XLEN-1:0] imm_i;
    logic [`CORE_XLEN-1:0] imm_b;
    logic [`CORE_XLEN-1:0] imm_j;
    logic [`CORE_XLEN-1:0] imm_u;
    logic [`CORE_XLEN-1:0] jalr_sum;

    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];
    assign rd_addr_o  = inst_i[11:7];

    // Sign-extended immediates, B and J scrambled per the ISA
    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
    assign imm_u = {inst_i[31:12], 12'b0};

    always_comb begin
        case (ctrl.op1_sel)
            core_ctrl_pkg::OP1_RS1: op1_o = rs1_data_i;
            core_ctrl_pkg::OP1_PC:  op1_o = pc_i;
            default:                op1_o = '0;
        endcase
        case (ctrl.op2_sel)
            core_ctrl_pkg::OP2_IMM_I: op2_o = imm_i;
            core_ctrl_pkg::OP2_IMM_U: op2_o = imm_u;
            default:                  op2_o = rs2_data_i;
        endcase
    end

    assign br_target_o  = pc_i + imm_b;
    assign jal_target_o = pc_i + imm_j;

    // JALR clears bit 0 of the sum
    assign jalr_sum      = rs1_data_i + imm_i;
    assign jalr_target_o = {jalr_sum[`CORE_XLEN-1:1], 1'b0};

    assign br_eq_o  = (rs1_data_i == rs2_data_i);
    assign br_lt_o  = ($signed(rs1_data_i) < $signed(rs2_data_i));
    assign br_ltu_o = (rs1_data_i < rs2_data_i);

endmodule

// ==== src/fetch_unit.sv ====
`include "core_consts.svh"
`timescale 1ns/1ps

module fetch_unit (
    input  logic                  clk,
    input  logic                  arst_n_i,
    core_ctrl_if.fetch            ctrl,
    input  logic [`CORE_XLEN-1:0] br_target_i,
    input  logic [`CORE_XLEN-1:0] jal_target_i,
    input  logic [`CORE_XLEN-1:0] jalr_target_i,
    input  logic [`CORE_XLEN-1:0] inst_i,
    output logic [`CORE_XLEN-1:0] pc_o,
    output logic [`CORE_XLEN-1:0] pc_plus4_o,
    output logic [`CORE_XLEN-1:0] inst_o
);

    logic [`CORE_XLEN-1:0] pc_q;
    logic [`CORE_XLEN-1:0] pc_next;

    assign pc_plus4_o = pc_q + `CORE_XLEN'(4);

    always_comb begin
        case (ctrl.pc_sel)
            core_ctrl_pkg::PC_BRANCH: pc_next = br_target_i;
            core_ctrl_pkg::PC_JAL:    pc_next = jal_target_i;
            core_ctrl_pkg::PC_JALR:   pc_next = jalr_target_i;
            core_ctrl_pkg::PC_HOLD:   pc_next = pc_q;
            default:                  pc_next = pc_plus4_o;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= `CORE_RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    assign pc_o   = pc_q;
    assign inst_o = inst_i;

    // Targets come from decode; none of them may break word alignment
    a_pc_aligned: assert property (
        @(posedge clk) disable iff (!arst_n_i) pc_q[1:0] == 2'b00
    );

endmodule

// ==== src/regfile.sv ====
`timescale 1ns/1ps

module regfile #(
    parameter int ADDR_WIDTH = 5,
    parameter int DATA_WIDTH = 32
) (
    input  logic                  clk,
    input  logic                  we_i,
    input  logic [ADDR_WIDTH-1:0] waddr_i,
    input  logic [DATA_WIDTH-1:0] wdata_i,
    input  logic [ADDR_WIDTH-1:0] raddr1_i,
    input  logic [ADDR_WIDTH-1:0] raddr2_i,
    input  logic [ADDR_WIDTH-1:0] dbg_raddr_i,
    output logic [DATA_WIDTH-1:0] rdata1_o,
    output logic [DATA_WIDTH-1:0] rdata2_o,
    output logic [DATA_WIDTH-1:0] dbg_rdata_o
);

    logic [DATA_WIDTH-1:0] regs [0:(1 << ADDR_WIDTH)-1];

    // Entry zero is never written, so mask it on every read
    function automatic logic [DATA_WIDTH-1:0] read_port(input logic [ADDR_WIDTH-1:0] addr);
        return (addr == '0) ? '0 : regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata1_o    = read_port(raddr1_i);
    assign rdata2_o    = read_port(raddr2_i);
    assign dbg_rdata_o = read_port(dbg_raddr_i);

endmodule

// ==== src/core_ctrl_if.sv ====
`timescale 1ns/1ps

interface core_ctrl_if;

    core_ctrl_pkg::pc_sel_e  pc_sel;
    core_ctrl_pkg::op1_sel_e op1_sel;
    core_ctrl_pkg::op2_sel_e op2_sel;
    rv_isa_pkg::alu_op_e     alu_op;
    core_ctrl_pkg::wb_sel_e  wb_sel;
    logic                    rf_we;

    // Driven by the control unit
    modport ctrl (output pc_sel, op1_sel, op2_sel, alu_op, wb_sel, rf_we);

    modport fetch (input pc_sel);

    modport decode (input op1_sel, op2_sel);

    modport exec (input alu_op, wb_sel);

endinterface

// ==== src/core_ctrl_pkg.sv ====
package core_ctrl_pkg;

    // Next PC source
    typedef enum logic [2:0] {
        PC_PLUS4,
        PC_BRANCH,
        PC_JAL,
        PC_JALR,
        PC_HOLD
    } pc_sel_e;

    typedef enum logic [1:0] {
        OP1_RS1,
        OP1_PC,
        OP1_ZERO
    } op1_sel_e;

    typedef enum logic [1:0] {
        OP2_RS2,
        OP2_IMM_I,
        OP2_IMM_U
    } op2_sel_e;

    // Register write-back source
    typedef enum logic {
        WB_ALU,
        WB_PC4
    } wb_sel_e;

endpackage

// ==== src/rv_isa_pkg.sv ====
package rv_isa_pkg;

    // RV32I major opcodes, the subset this core decodes
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011,
        SYSTEM = 7'b1110011
    } opcode_e;

    // funct3 of OP and OP_IMM
    typedef enum logic [2:0] {
        F3_ADD  = 3'b000,
        F3_SLL  = 3'b001,
        F3_SLT  = 3'b010,
        F3_SLTU = 3'b011,
        F3_XOR  = 3'b100,
        F3_SR   = 3'b101,
        F3_OR   = 3'b110,
        F3_AND  = 3'b111
    } alu_funct3_e;

    // funct3 of BRANCH
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } br_funct3_e;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND,
        COPY2   // passes operand 2 through
    } alu_op_e;

endpackage

// ==== src/core_consts.svh ====
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

`define CORE_XLEN 32
`define CORE_REG_AW 5

// First fetch address after reset
`define CORE_RESET_PC 32'h8000_0000

`define CORE_EBREAK 32'h0010_0073

`endif
